// ==== cpu_cfg_pkg.sv ====
package cpu_cfg_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Data RAM geometry, word addressed
    localparam int RAM_WORDS  = 64;
    localparam int RAM_ADDR_W = 6;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Stores here go to the output port and not the RAM
    localparam logic [XLEN-1:0] IO_ADDR  = 32'h0000_0100;

    // One instruction in flight, stepped through these
    typedef enum logic [2:0] {
        PH_FETCH,
        PH_DECODE,
        PH_EXECUTE,
        PH_MEMORY,
        PH_WRITEBACK
    } phase_t;

endpackage

// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_kind_t;

    // Bit positions inside the instruction word
    localparam int RD_LSB         = 7;
    localparam int FUNCT3_LSB     = 12;
    localparam int RS1_LSB        = 15;
    localparam int RS2_LSB        = 20;
    localparam int FUNCT7_SUB_BIT = 30;  // Selects SUB over ADD

    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;
    localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
    localparam logic [2:0] FUNCT3_BNE     = 3'b001;

endpackage

// ==== register_bank.sv ====
`timescale 1ns/1ps

module register_bank (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                enable,
    input  logic                                write_enable,
    input  logic [cpu_cfg_pkg::REG_ADDR_W-1:0]  write_address,
    input  logic [cpu_cfg_pkg::XLEN-1:0]        write_value,
    input  logic [cpu_cfg_pkg::REG_ADDR_W-1:0]  read_address1,
    input  logic [cpu_cfg_pkg::REG_ADDR_W-1:0]  read_address2,
    output logic [cpu_cfg_pkg::XLEN-1:0]        value1,
    output logic [cpu_cfg_pkg::XLEN-1:0]        value2
);
    import cpu_cfg_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (enable && write_enable && write_address != '0) begin
            regs[write_address] <= write_value;  // x0 never written
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign value1 = (read_address1 == '0) ? '0 : regs[read_address1];
    assign value2 = (read_address2 == '0) ? '0 : regs[read_address2];

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [cpu_cfg_pkg::XLEN-1:0] operand_a,
    input  logic [cpu_cfg_pkg::XLEN-1:0] operand_b,
    input  cpu_isa_pkg::alu_op_t         alu_op,
    output logic [cpu_cfg_pkg::XLEN-1:0] result,
    output logic                         equal
);
    import cpu_isa_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = operand_a - operand_b;
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_XOR: result = operand_a ^ operand_b;
            ALU_SLT: begin
                // Signed compare, result is 0 or 1
                result = ($signed(operand_a) < $signed(operand_b)) ? 1 : 0;
            end
            default: result = '0;
        endcase
    end

    assign equal = (operand_a == operand_b);  // For BEQ and BNE

endmodule

// ==== immediate_gen.sv ====
`timescale 1ns/1ps

module immediate_gen (
    input  logic [cpu_cfg_pkg::XLEN-1:0] instr,
    input  cpu_isa_pkg::imm_kind_t       imm_kind,
    output logic [cpu_cfg_pkg::XLEN-1:0] imm
);
    import cpu_isa_pkg::*;

    always_comb begin
        case (imm_kind)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                // Offset in half words, bit 0 implied
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: imm = {instr[31:12], 12'b0};  // Upper 20 bits
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== ram.sv ====
`timescale 1ns/1ps

module ram (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         enable,
    input  logic [cpu_cfg_pkg::XLEN-1:0] address,
    input  logic [cpu_cfg_pkg::XLEN-1:0] data_in,
    input  logic                         write_enable,
    input  logic                         read_enable,
    output logic [cpu_cfg_pkg::XLEN-1:0] data_out,
    output logic [cpu_cfg_pkg::XLEN-1:0] io_data,
    output logic                         io_write
);
    import cpu_cfg_pkg::*;

    logic [XLEN-1:0]       mem [RAM_WORDS];
    logic [RAM_ADDR_W-1:0] word_index;
    logic                  is_io;

    assign word_index = address[RAM_ADDR_W+1:2];  // Byte to word address
    assign is_io      = (address == IO_ADDR);

    always_ff @(posedge clock) begin
        if (enable) begin
            if (write_enable && !is_io) begin
                mem[word_index] <= data_in;
            end
            if (read_enable) begin
                data_out <= mem[word_index];  // Ready in the next phase
            end
        end
    end

    // One pulse per I/O store
    always_ff @(posedge clock) begin
        if (reset) begin
            io_write <= 1'b0;
        end else if (enable) begin
            io_write <= write_enable && is_io;
        end
    end

    always_ff @(posedge clock) begin
        if (enable && write_enable && is_io) begin
            io_data <= data_in;
        end
    end

endmodule

// ==== control.sv ====
`timescale 1ns/1ps

module control (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                enable,
    input  logic [cpu_cfg_pkg::XLEN-1:0]        rom_data,
    input  logic [cpu_cfg_pkg::XLEN-1:0]        value1,
    input  logic [cpu_cfg_pkg::XLEN-1:0]        value2,
    input  logic [cpu_cfg_pkg::XLEN-1:0]        imm,
    input  logic [cpu_cfg_pkg::XLEN-1:0]        alu_result,
    input  logic                                alu_equal,
    input  logic [cpu_cfg_pkg::XLEN-1:0]        mem_read_data,
    output logic [cpu_cfg_pkg::XLEN-1:0]        rom_address,
    output logic [cpu_cfg_pkg::REG_ADDR_W-1:0]  rs1,
    output logic [cpu_cfg_pkg::REG_ADDR_W-1:0]  rs2,
    output logic [cpu_cfg_pkg::XLEN-1:0]        instr,
    output cpu_isa_pkg::imm_kind_t              imm_kind,
    output logic [cpu_cfg_pkg::XLEN-1:0]        operand_a,
    output logic [cpu_cfg_pkg::XLEN-1:0]        operand_b,
    output cpu_isa_pkg::alu_op_t                alu_op,
    output logic [cpu_cfg_pkg::XLEN-1:0]        mem_addr,
    output logic [cpu_cfg_pkg::XLEN-1:0]        mem_write_data,
    output logic                                mem_write,
    output logic                                mem_read,
    output logic                                rb_write_enable,
    output logic [cpu_cfg_pkg::REG_ADDR_W-1:0]  rb_write_address,
    output logic [cpu_cfg_pkg::XLEN-1:0]        rb_write_value,
    output logic [5:0]                          led
);
    import cpu_isa_pkg::*;
    import cpu_cfg_pkg::*;

    phase_t          phase;
    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] ir;        // Instruction register
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] imm_q;
    logic [XLEN-1:0] result_q;  // ALU result or JAL link
    logic            reg_write;
    logic            alu_src_imm;
    logic            zero_a;    // LUI adds the immediate to zero
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            is_jal;
    logic            take_branch;

    assign opcode = opcode_t'(ir[$bits(opcode_t)-1:0]);
    assign funct3 = ir[FUNCT3_LSB +: 3];

    always_comb begin
        reg_write   = 1'b0;
        alu_src_imm = 1'b0;
        zero_a      = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_branch   = 1'b0;
        is_jal      = 1'b0;
        alu_op      = ALU_ADD;
        imm_kind    = IMM_I;
        case (opcode)
            OP_REG: begin
                reg_write = 1'b1;
                case (funct3)
                    FUNCT3_ADD_SUB: alu_op = ir[FUNCT7_SUB_BIT] ? ALU_SUB : ALU_ADD;
                    FUNCT3_SLT:     alu_op = ALU_SLT;
                    FUNCT3_XOR:     alu_op = ALU_XOR;
                    FUNCT3_OR:      alu_op = ALU_OR;
                    FUNCT3_AND:     alu_op = ALU_AND;
                    default:        reg_write = 1'b0;  // Shifts not supported
                endcase
            end
            OP_IMM: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                zero_a      = 1'b1;
                imm_kind    = IMM_U;
            end
            OP_LOAD: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                is_load     = 1'b1;
            end
            OP_STORE: begin
                alu_src_imm = 1'b1;
                is_store    = 1'b1;
                imm_kind    = IMM_S;
            end
            OP_BRANCH: begin
                is_branch = 1'b1;
                imm_kind  = IMM_B;
            end
            OP_JAL: begin
                reg_write = 1'b1;
                is_jal    = 1'b1;
                imm_kind  = IMM_J;
            end
            default: ;  // Unknown opcode runs as a no-op
        endcase
    end

    assign rom_address = pc;
    assign instr       = ir;
    assign rs1         = ir[RS1_LSB +: REG_ADDR_W];
    assign rs2         = ir[RS2_LSB +: REG_ADDR_W];

    // Branches compare rs1 and rs2 in the ALU
    assign operand_a = zero_a ? '0 : rs1_q;
    assign operand_b = alu_src_imm ? imm_q : rs2_q;

    assign take_branch = is_branch && ((funct3 == FUNCT3_BEQ && alu_equal) ||
                                       (funct3 == FUNCT3_BNE && !alu_equal));
    assign pc_plus4    = pc + 32'd4;
    assign next_pc     = (take_branch || is_jal) ? pc + imm_q : pc_plus4;

    assign mem_addr       = result_q;
    assign mem_write_data = rs2_q;
    assign mem_write      = (phase == PH_MEMORY) && is_store;
    assign mem_read       = (phase == PH_MEMORY) && is_load;

    assign rb_write_enable  = (phase == PH_WRITEBACK) && reg_write;
    assign rb_write_address = ir[RD_LSB +: REG_ADDR_W];
    assign rb_write_value   = is_load ? mem_read_data : result_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= PH_FETCH;
            pc    <= RESET_PC;
            led   <= '0;
        end else if (enable) begin
            case (phase)
                PH_FETCH:   phase <= PH_DECODE;
                PH_DECODE:  phase <= PH_EXECUTE;
                PH_EXECUTE: begin
                    pc    <= next_pc;
                    phase <= (is_load || is_store) ? PH_MEMORY : PH_WRITEBACK;
                end
                PH_MEMORY:  phase <= PH_WRITEBACK;
                PH_WRITEBACK: begin
                    if (rb_write_enable && rb_write_address != '0) begin
                        led <= rb_write_value[5:0];
                    end
                    phase <= PH_FETCH;
                end
                default:    phase <= PH_FETCH;
            endcase
        end
    end

    // Per-phase latches
    always_ff @(posedge clock) begin
        if (enable) begin
            case (phase)
                PH_FETCH:   ir <= rom_data;
                PH_DECODE: begin
                    rs1_q <= value1;
                    rs2_q <= value2;
                    imm_q <= imm;
                end
                PH_EXECUTE: result_q <= is_jal ? pc_plus4 : alu_result;
                default: ;
            endcase
        end
    end

endmodule

// ==== cpu.sv ====
`timescale 1ns/1ps

module cpu (
    input  logic                         clock,
    input  logic                         reset,
    output logic [5:0]                   led,
    input  logic                         enable,
    input  logic [cpu_cfg_pkg::XLEN-1:0] rom_data,
    output logic [cpu_cfg_pkg::XLEN-1:0] rom_address,
    output logic [cpu_cfg_pkg::XLEN-1:0] io_data,
    output logic                         io_write
);
    import cpu_isa_pkg::*;
    import cpu_cfg_pkg::*;

    // Register bank
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rb_value1;
    logic [XLEN-1:0]       rb_value2;
    logic                  rb_write_enable;
    logic [REG_ADDR_W-1:0] rb_write_address;
    logic [XLEN-1:0]       rb_write_value;

    // Immediate and ALU
    logic [XLEN-1:0] instr;
    imm_kind_t       imm_kind;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    alu_op_t         alu_op;
    logic [XLEN-1:0] alu_result;
    logic            alu_equal;

    // Data RAM
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_write_data;
    logic [XLEN-1:0] mem_read_data;
    logic            mem_write;
    logic            mem_read;

    control control_unit (
        .clock            (clock),
        .reset            (reset),
        .enable           (enable),
        .rom_data         (rom_data),
        .value1           (rb_value1),
        .value2           (rb_value2),
        .imm              (imm),
        .alu_result       (alu_result),
        .alu_equal        (alu_equal),
        .mem_read_data    (mem_read_data),
        .rom_address      (rom_address),
        .rs1              (rs1),
        .rs2              (rs2),
        .instr            (instr),
        .imm_kind         (imm_kind),
        .operand_a        (operand_a),
        .operand_b        (operand_b),
        .alu_op           (alu_op),
        .mem_addr         (mem_addr),
        .mem_write_data   (mem_write_data),
        .mem_write        (mem_write),
        .mem_read         (mem_read),
        .rb_write_enable  (rb_write_enable),
        .rb_write_address (rb_write_address),
        .rb_write_value   (rb_write_value),
        .led              (led)
    );

    register_bank reg_bank (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .write_enable  (rb_write_enable),
        .write_address (rb_write_address),
        .write_value   (rb_write_value),
        .read_address1 (rs1),
        .read_address2 (rs2),
        .value1        (rb_value1),
        .value2        (rb_value2)
    );

    immediate_gen imm_gen (
        .instr    (instr),
        .imm_kind (imm_kind),
        .imm      (imm)
    );

    alu alu_unit (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .alu_op    (alu_op),
        .result    (alu_result),
        .equal     (alu_equal)
    );

    ram data_ram (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .address      (mem_addr),
        .data_in      (mem_write_data),
        .write_enable (mem_write),
        .read_enable  (mem_read),
        .data_out     (mem_read_data),
        .io_data      (io_data),
        .io_write     (io_write)
    );

endmodule

// ==== cpu_props.sv ====
`timescale 1ns/1ps

module cpu_props (
    input  logic                         clock,
    input  logic                         reset,
    input  cpu_cfg_pkg::phase_t          phase,
    input  logic [cpu_cfg_pkg::XLEN-1:0] rom_address,
    input  logic                         rb_write_enable,
    input  logic                         mem_write
);
    import cpu_cfg_pkg::*;

    int failures = 0;  // Failed assertions so far

    // Sync reset parks the FSM in fetch
    phase_after_reset: assert property (@(posedge clock) reset |=> phase == PH_FETCH)
        else begin
            $error("phase is not PH_FETCH after reset");
            failures++;
        end

    rom_word_aligned: assert property (@(posedge clock) disable iff (reset)
        rom_address[1:0] == 2'b00)
        else begin
            $error("rom_address is not word aligned");
            failures++;
        end

    write_back_only: assert property (@(posedge clock) disable iff (reset)
        rb_write_enable |-> phase == PH_WRITEBACK)
        else begin
            $error("register write outside PH_WRITEBACK");
            failures++;
        end

    store_in_memory_only: assert property (@(posedge clock) disable iff (reset)
        mem_write |-> phase == PH_MEMORY)
        else begin
            $error("mem_write outside PH_MEMORY");
            failures++;
        end

endmodule

bind control cpu_props control_props (
    .clock           (clock),
    .reset           (reset),
    .phase           (phase),
    .rom_address     (rom_address),
    .rb_write_enable (rb_write_enable),
    .mem_write       (mem_write)
);

// ==== cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import cpu_cfg_pkg::*;

    localparam int ROM_WORDS = 256;
    localparam int MAX_TESTS = 16;
    localparam int MAX_WORDS = 512;
    localparam     TEST_FILE = "cpu_tests.txt";

    logic            clock;
    logic            reset;
    logic            enable;
    logic [XLEN-1:0] rom_data;
    logic [XLEN-1:0] rom_address;
    logic [5:0]      led;
    logic [XLEN-1:0] io_data;
    logic            io_write;

    logic [XLEN-1:0] rom [ROM_WORDS];

    // Contents of the test file
    logic [8*24-1:0] test_name [MAX_TESTS];
    bit              restart_after_first [MAX_TESTS];
    int              prog_base [MAX_TESTS];
    int              prog_len [MAX_TESTS];
    int              out_base [MAX_TESTS];
    int              out_len [MAX_TESTS];
    logic [5:0]      led_expected [MAX_TESTS];
    logic [XLEN-1:0] prog_mem [MAX_WORDS];
    logic [XLEN-1:0] out_mem [MAX_WORDS];
    int              num_tests;
    int              prog_count;
    int              out_count;
    bit              tests_loaded;

    int          error_count;
    int          tests_run;
    int          tests_passed;
    int          cur_test;
    int          io_count;      // Outputs seen in the running test
    longint      timeout_ns;

    always #50 clock = ~clock;

    // ROM answers in the same cycle, 256 words
    assign rom_data = (rom_address < ROM_WORDS * 4) ? rom[rom_address[9:2]] : '0;

    cpu DUT (
        .clock       (clock),
        .reset       (reset),
        .led         (led),
        .enable      (enable),
        .rom_data    (rom_data),
        .rom_address (rom_address),
        .io_data     (io_data),
        .io_write    (io_write)
    );

    task automatic check_word(input string signal_name,
                              input logic [cpu_cfg_pkg::XLEN-1:0] actual,
                              input logic [cpu_cfg_pkg::XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, signal_name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_led(input logic [5:0] actual, input logic [5:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: led is %h, expected %h", $time, actual, expected);
            error_count++;
        end
    endtask

    task automatic load_tests();
        int              fd;
        int              code;
        int              count;
        int              flag;
        logic [8*128-1:0] line;
        logic [8*16-1:0] keyword;
        logic [8*24-1:0] name;
        logic [XLEN-1:0] value;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test file %0s", TEST_FILE);
            error_count++;
        end else begin
            while ($fscanf(fd, "%s", keyword) == 1) begin
                if (keyword == "#") begin
                    code = $fgets(line, fd);  // Rest of a comment line
                end else if (keyword == "test") begin
                    name = '0;
                    code = $fscanf(fd, "%s %d", name, flag);
                    test_name[num_tests] = name;
                    restart_after_first[num_tests] = (flag != 0);
                    prog_base[num_tests] = prog_count;
                    out_base[num_tests] = out_count;
                    num_tests++;
                end else if (keyword == "prog") begin
                    code = $fscanf(fd, "%d", count);
                    prog_len[num_tests-1] = count;
                    for (int i = 0; i < count; i++) begin
                        code = $fscanf(fd, "%h", value);
                        prog_mem[prog_count] = value;
                        prog_count++;
                    end
                end else if (keyword == "out") begin
                    code = $fscanf(fd, "%d", count);
                    out_len[num_tests-1] = count;
                    for (int i = 0; i < count; i++) begin
                        code = $fscanf(fd, "%h", value);
                        out_mem[out_count] = value;
                        out_count++;
                    end
                end else if (keyword == "led") begin
                    code = $fscanf(fd, "%h", value);
                    led_expected[num_tests-1] = value[5:0];
                end else begin
                    $display("Unknown keyword %0s in %0s", keyword, TEST_FILE);
                    error_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic load_rom(input int t);
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = (i < prog_len[t]) ? prog_mem[prog_base[t] + i] : '0;
        end
    endtask

    // Called on a falling edge, returns on one
    task automatic hold_reset();
        reset  = 1'b1;
        enable = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic run_test(input int t, input bit random_enable);
        int              errors_before;
        bit              restarted;
        bit              done;
        logic [XLEN-1:0] halt_address;
        errors_before = error_count;
        restarted     = 1'b0;
        done          = 1'b0;
        halt_address  = (prog_len[t] - 1) * 4;  // Program ends in a jump to itself
        cur_test      = t;
        io_count      = 0;
        tests_run++;
        @(negedge clock);
        load_rom(t);
        hold_reset();
        while (!done) begin
            @(negedge clock);
            // A held io_write only counts on the edge that set it
            if (io_write && enable) begin
                if (io_count < out_len[t]) begin
                    check_word("io_data", io_data, out_mem[out_base[t] + io_count]);
                end else begin
                    $display("Unexpected output %h from test %0s at %0t ns",
                             io_data, test_name[t], $time);
                    error_count++;
                end
                io_count++;
                if (restart_after_first[t] && !restarted) begin
                    restarted = 1'b1;
                    hold_reset();
                    io_count = 0;
                end
            end
            if (io_count >= out_len[t] && rom_address == halt_address) begin
                done = 1'b1;
            end
            enable = random_enable ? (($urandom % 4) != 0) : 1'b1;
        end
        check_led(led, led_expected[t]);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("PASS %0s with %s enable, %0d outputs", test_name[t],
                     random_enable ? "random" : "steady", io_count);
        end else begin
            $display("FAIL %0s with %s enable, %0d outputs", test_name[t],
                     random_enable ? "random" : "steady", io_count);
        end
    endtask

    initial begin
        clock  = 1'b0;
        reset  = 1'b1;
        enable = 1'b1;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
        void'($urandom(27));
        load_tests();
        timeout_ns = longint'(prog_count > 0 ? prog_count : 1) * 5 * 8 * 100;
        tests_loaded = 1'b1;
        // Second pass repeats every test with random stalls
        for (int pass = 0; pass < 2; pass++) begin
            for (int t = 0; t < num_tests; t++) begin
                run_test(t, pass == 1);
            end
        end
        // Failed assertions of the bound checker count as errors
        error_count += DUT.control_unit.control_props.failures;
        $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
                 tests_run, tests_passed, tests_run - tests_passed, error_count);
        if (error_count == 0 && tests_run > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        wait (tests_loaded);
        #(timeout_ns);
        $display("Timeout in test %0s, only %0d of %0d outputs arrived",
                 test_name[cur_test], io_count, out_len[cur_test]);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== cpu_tests.txt ====
# test <name> <1 = reset after the first output>, prog <count> <hex words>
# out <count> <expected io_data words>, led <expected led in hex>
test reg_arith 0
prog 19
FA500093 12345137 67810113 10000F93 001124B3 009FA023
0020A433 008FA023 002081B3 003FA023 40110233 004FA023
0020F2B3 005FA023 0020E333 006FA023 0020C3B3 007FA023
0000006F
out 7
00000000 00000001 1234561D 123456D3 12345620 FFFFFFFD EDCBA9DD
led 1D
test immediates 0
prog 16
10000F93 FFF00093 001FA023 80000113 002FA023 7FF00193
003FA023 FFFFF237 004FA023 800002B7 FFF28293 005FA023
00500013 12345037 000FA023 0000006F
out 6
FFFFFFFF FFFFF800 000007FF FFFFF000 7FFFFFFF 00000000
led 3F
test mem_round_trip 0
prog 18
10000F93 CAFE00B7 12308093 FAB00113 05500193 00102023
00202423 0E302E23 003FA023 00002203 00802283 0FC02303
FFCFA383 004FA023 005FA023 006FA023 007FA023 0000006F
out 5
00000055 CAFE0123 FFFFFFAB 00000055 00000055
led 15
test branches_jal 0
prog 18
10000F93 00500093 00500113 00700193 09900493 00208463
009FA023 001FA023 00308463 003FA023 00309463 009FA023
00209463 01FFA023 008002EF 009FA023 005FA023 0000006F
out 4
00000005 00000007 00000100 0000003C
led 3C
test reset_restart 1
prog 8
10000F93 02100093 001FA023 00108093 001FA023 00108093
001FA023 0000006F
out 3
00000021 00000022 00000023
led 23

// ==== tb.f ====
cpu_cfg_pkg.sv
cpu_isa_pkg.sv
register_bank.sv
alu.sv
immediate_gen.sv
ram.sv
control.sv
cpu.sv
cpu_props.sv
cpu_tb.sv
